//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_usb_ctrl
FLIST     ?= compile.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build, run, then search the log for the fail message
sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST RESULT: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
source/usb_ctrl_pkg.sv
source/byte_stream_if.sv
source/usb_rx_reader.sv
source/cmd_fifo.sv
source/cmd_decoder.sv
source/usb_tx_writer.sv
source/usb_ctrl_top.sv
tb/tb_usb_ctrl.sv

//--- source/byte_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if
    import usb_ctrl_pkg::*;
();

    logic  push;         // write one byte into the buffer
    byte_t push_data;    // byte to write
    logic  full;         // buffer has no free slot
    logic  pop;          // consume the oldest byte
    byte_t pop_data;     // oldest byte, valid while not empty
    logic  empty;        // buffer holds nothing

    modport producer
    (
        output push, push_data,
        input  full
    );

    modport buffer
    (
        input  push, push_data, pop,
        output full, pop_data, empty
    );

    modport consumer
    (
        output pop,
        input  pop_data, empty
    );

endinterface

`default_nettype wire

//--- source/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import usb_ctrl_pkg::*;
(
    input  logic             I_sys_clk,
    input  logic             I_sys_rst,
    input  logic             motor_busy,
    byte_stream_if.consumer  stream,
    output usb_dir_e         usb_dir,
    output logic             motor_start
);

//==========================================================================
// pop and decode
//==========================================================================
// hold off one cycle behind a start pulse so back-to-back 0x02
// bytes still give separate pulses
assign stream.pop = !stream.empty && !motor_busy && !motor_start;

always_ff @(posedge I_sys_clk)
begin
    if (I_sys_rst)
    begin
        usb_dir     <= DIR_TO_USB;
        motor_start <= 1'b0;
    end
    else
    begin
        motor_start <= 1'b0;                 // pulse lasts one cycle
        if (stream.pop)
        begin
            case (stream.pop_data)
                CMD_DIR_TO_USB:
                begin
                    usb_dir <= DIR_TO_USB;   // wr to usb
                end
                CMD_DIR_FROM_USB:
                begin
                    usb_dir <= DIR_FROM_USB; // rd from usb
                end
                CMD_MOTOR_START:
                begin
                    motor_start <= 1'b1;
                end
                default:
                begin
                    usb_dir <= usb_dir;      // unknown byte is dropped
                end
            endcase
        end
    end
end

//==========================================================================
// checks
//==========================================================================
a_start_is_pulse: assert property (
    @(posedge I_sys_clk) disable iff (I_sys_rst)
    motor_start |=> !motor_start
);

endmodule

`default_nettype wire

//--- source/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo
    import usb_ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 8            // bytes, power of two
)
(
    input  logic           I_sys_clk,
    input  logic           I_sys_rst,
    byte_stream_if.buffer  stream
);

localparam int PTR_W = $clog2(FIFO_DEPTH);
localparam int CNT_W = PTR_W + 1;           // holds 0 .. FIFO_DEPTH

//==========================================================================
// storage and pointers
//==========================================================================
byte_t             mem [FIFO_DEPTH];
logic [PTR_W-1:0]  wr_ptr;
logic [PTR_W-1:0]  rd_ptr;
logic [CNT_W-1:0]  count;                   // occupancy
logic              wr_en;
logic              rd_en;

assign wr_en = stream.push && !stream.full;
assign rd_en = stream.pop && !stream.empty;

always_ff @(posedge I_sys_clk)
begin
    if (wr_en)
    begin
        mem[wr_ptr] <= stream.push_data;
    end
end

// pointers wrap naturally since the depth is a power of two
always_ff @(posedge I_sys_clk)
begin
    if (I_sys_rst)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end
    else
    begin
        if (wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (rd_en)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // idle or push and pop together
        endcase
    end
end

assign stream.full     = (count == CNT_W'(FIFO_DEPTH));
assign stream.empty    = (count == '0);
assign stream.pop_data = mem[rd_ptr];       // oldest entry, shown ahead

//==========================================================================
// checks on the neighbours
//==========================================================================
a_no_push_when_full: assert property (
    @(posedge I_sys_clk) disable iff (I_sys_rst)
    stream.push |-> !stream.full
);

a_no_pop_when_empty: assert property (
    @(posedge I_sys_clk) disable iff (I_sys_rst)
    stream.pop |-> !stream.empty
);

endmodule

`default_nettype wire

//--- source/usb_ctrl_pkg.sv
`default_nettype none

package usb_ctrl_pkg;

    //==========================================================================
    // byte and direction types
    //==========================================================================
    typedef logic [7:0] byte_t;              // one command or data byte

    typedef enum logic
    {
        DIR_TO_USB   = 1'b0,                 // write toward the host
        DIR_FROM_USB = 1'b1                  // read from the host
    } usb_dir_e;

    //==========================================================================
    // command codes seen on the receive side
    //==========================================================================
    localparam byte_t CMD_DIR_TO_USB   = 8'h00;  // select write-to-usb
    localparam byte_t CMD_DIR_FROM_USB = 8'hFF;  // select read-from-usb
    localparam byte_t CMD_MOTOR_START  = 8'h02;  // one motor start pulse

    // any other value is consumed without effect

    //==========================================================================
    // transmit side
    //==========================================================================
    localparam byte_t ACK_BYTE = 8'h55;          // sent once per key press

endpackage

`default_nettype wire

//--- source/usb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_ctrl_top
    import usb_ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 8            // command buffer depth
)
(
    input  logic      I_sys_clk,
    input  logic      I_sys_rst,

    //======================================================================
    // bridge receive side
    //======================================================================
    input  byte_t     rx_data,
    input  logic      rx_empty,
    output logic      rx_req,

    //======================================================================
    // bridge transmit side
    //======================================================================
    input  logic      tx_full,
    output logic      tx_req,
    output byte_t     tx_data,

    //======================================================================
    // board side
    //======================================================================
    input  logic      key_start,
    input  logic      motor_busy,
    output usb_dir_e  usb_dir,
    output logic      motor_start
);

byte_stream_if cmd_stream ();               // reader -> fifo -> decoder

usb_rx_reader u_rx_reader
(
    .I_sys_clk   (I_sys_clk),
    .I_sys_rst   (I_sys_rst),
    .rx_empty    (rx_empty),
    .rx_data     (rx_data),
    .rx_req      (rx_req),
    .stream      (cmd_stream.producer)
);

cmd_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH)
) u_cmd_fifo
(
    .I_sys_clk   (I_sys_clk),
    .I_sys_rst   (I_sys_rst),
    .stream      (cmd_stream.buffer)
);

cmd_decoder u_cmd_decoder
(
    .I_sys_clk   (I_sys_clk),
    .I_sys_rst   (I_sys_rst),
    .motor_busy  (motor_busy),
    .stream      (cmd_stream.consumer),
    .usb_dir     (usb_dir),
    .motor_start (motor_start)
);

usb_tx_writer u_tx_writer
(
    .I_sys_clk   (I_sys_clk),
    .I_sys_rst   (I_sys_rst),
    .key_start   (key_start),
    .tx_full     (tx_full),
    .tx_req      (tx_req),
    .tx_data     (tx_data)
);

endmodule

`default_nettype wire

//--- source/usb_rx_reader.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_reader
    import usb_ctrl_pkg::*;
(
    input  logic             I_sys_clk,
    input  logic             I_sys_rst,
    input  logic             rx_empty,
    input  byte_t            rx_data,
    output logic             rx_req,
    byte_stream_if.producer  stream
);

//==========================================================================
// in-flight read sequence
//==========================================================================
localparam logic [1:0] RD_IDLE    = 2'd0;   // free to strobe
localparam logic [1:0] RD_CAPTURE = 2'd1;   // bridge shows the byte now
localparam logic [1:0] RD_PUSH    = 2'd2;   // byte goes into the buffer

logic [1:0] rd_state;
byte_t      rx_byte;                        // byte returned by the bridge

// one read in flight at a time, so full is never stale when we strobe
assign rx_req = (rd_state == RD_IDLE) && !rx_empty && !stream.full;

always_ff @(posedge I_sys_clk)
begin
    if (I_sys_rst)
    begin
        rd_state <= RD_IDLE;
    end
    else
    begin
        case (rd_state)
            RD_IDLE:
            begin
                if (rx_req)
                begin
                    rd_state <= RD_CAPTURE;
                end
            end
            RD_CAPTURE:
            begin
                rd_state <= RD_PUSH;
            end
            default:
            begin
                rd_state <= RD_IDLE;        // back to idle after the push
            end
        endcase
    end
end

always_ff @(posedge I_sys_clk)
begin
    if (rd_state == RD_CAPTURE)
    begin
        rx_byte <= rx_data;                 // latch one cycle after strobe
    end
end

assign stream.push      = (rd_state == RD_PUSH);
assign stream.push_data = rx_byte;

//==========================================================================
// checks
//==========================================================================
a_no_strobe_when_empty: assert property (
    @(posedge I_sys_clk) disable iff (I_sys_rst)
    rx_req |-> !rx_empty
);

endmodule

`default_nettype wire

//--- source/usb_tx_writer.sv
`timescale 1ns/1ps
`default_nettype none

module usb_tx_writer
    import usb_ctrl_pkg::*;
(
    input  logic   I_sys_clk,
    input  logic   I_sys_rst,
    input  logic   key_start,
    input  logic   tx_full,
    output logic   tx_req,
    output byte_t  tx_data
);

logic key_q;                                // key one cycle ago
logic key_rise;
logic ack_pending;                          // ack owed to the bridge

//==========================================================================
// key edge and pending request
//==========================================================================
assign key_rise = key_start && !key_q;

always_ff @(posedge I_sys_clk)
begin
    key_q <= key_start;
end

// edges arriving while a request is owed fold into it
always_ff @(posedge I_sys_clk)
begin
    if (I_sys_rst)
    begin
        ack_pending <= 1'b0;
    end
    else if (tx_req)
    begin
        ack_pending <= 1'b0;                // written this cycle
    end
    else if (key_rise)
    begin
        ack_pending <= 1'b1;
    end
end

//==========================================================================
// bridge write
//==========================================================================
assign tx_req  = ack_pending && !tx_full;   // wait for room
assign tx_data = ACK_BYTE;

endmodule

`default_nettype wire

//--- tb/tb_usb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_ctrl
    import usb_ctrl_pkg::*;
();

localparam int FIFO_DEPTH = 8;
localparam int SETTLE_MAX = 64;                 // cycles allowed to reach the expected state
localparam int DRAIN      = 2 * FIFO_DEPTH + 4; // quiet tail to catch late extras

logic     I_sys_clk  = 1'b0;
logic     I_sys_rst  = 1'b1;
byte_t    rx_data    = '0;
logic     rx_empty   = 1'b1;
logic     tx_full    = 1'b0;
logic     key_start  = 1'b0;
logic     motor_busy = 1'b0;
logic     rx_req;
logic     tx_req;
byte_t    tx_data;
usb_dir_e usb_dir;
logic     motor_start;

byte_t           rx_q [$];                      // bridge receive FIFO contents
byte_t           rx_next     = '0;              // byte shown after a strobe
byte_t           tx_seen     = ACK_BYTE;        // first wrong tx byte of a test
logic [8*24-1:0] tname       = '0;
int              seed        = 34824;
int              pulse_cnt   = 0;
int              ack_cnt     = 0;
int              err_cnt     = 0;
int              busy_left   = 0;
int              full_left   = 0;
int              cycle_cnt   = 0;
int              cycle_limit = 0;
int              pass_cnt    = 0;
int              fail_cnt    = 0;
bit              test_ok     = 1'b1;

always #50 I_sys_clk = ~I_sys_clk;

usb_ctrl_top #(
    .FIFO_DEPTH  (FIFO_DEPTH)
) dut_i
(
    .I_sys_clk   (I_sys_clk),
    .I_sys_rst   (I_sys_rst),
    .rx_data     (rx_data),
    .rx_empty    (rx_empty),
    .rx_req      (rx_req),
    .tx_full     (tx_full),
    .tx_req      (tx_req),
    .tx_data     (tx_data),
    .key_start   (key_start),
    .motor_busy  (motor_busy),
    .usb_dir     (usb_dir),
    .motor_start (motor_start)
);

//==========================================================================
// bridge model and monitor sampled on the rising edge
//==========================================================================
always @(posedge I_sys_clk)
begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end
    else if (!I_sys_rst)
    begin
        if (rx_req && rx_empty)
        begin
            $display("rx_req was strobed while the bridge receive FIFO was empty");
            err_cnt++;
        end
        else if (rx_req)
            rx_next = rx_q.pop_front();     // shown on the next cycle
        if (tx_req && tx_full)
        begin
            $display("tx_req was written while the bridge transmit FIFO was full");
            err_cnt++;
        end
        if (tx_req)
            ack_cnt++;
        if (tx_req && tx_data != ACK_BYTE)
            tx_seen = tx_data;
        if (motor_start)
            pulse_cnt++;
    end
end

// all inputs change on the falling edge
task automatic step_cycle();
    @(negedge I_sys_clk);
    motor_busy = (busy_left > 0);
    tx_full    = (full_left > 0);
    rx_empty   = (rx_q.size() == 0);
    rx_data    = rx_next;
    if (busy_left > 0)
        busy_left--;
    if (full_left > 0)
        full_left--;
endtask

function automatic byte_t filler_byte();
    byte_t b;
    b = byte_t'($random(seed));
    while (b == 8'h00 || b == 8'hFF || b == 8'h02)
        b = byte_t'($random(seed));         // never a command code
    return b;
endfunction

task automatic check_dir(input usb_dir_e exp, input usb_dir_e act);
    if (act !== exp)
    begin
        $display("MISMATCH %0s usb_dir expected %0d actual %0d", tname, exp, act);
        test_ok = 1'b0;
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    if (act != exp)
    begin
        $display("MISMATCH %0s %0s expected %0d actual %0d", tname, what, exp, act);
        test_ok = 1'b0;
    end
endtask

task automatic check_byte(input byte_t exp, input byte_t act);
    if (act !== exp)
    begin
        $display("MISMATCH %0s tx_data expected %02h actual %02h", tname, exp, act);
        test_ok = 1'b0;
    end
endtask

task automatic run_op(input byte op, input int n);
    case (op)
        "r": repeat (n) rx_q.push_back(filler_byte());
        "f": full_left = n;
        "b": busy_left = n;
        "k":
        begin
            key_start = 1'b1;
            repeat (n) step_cycle();
            key_start = 1'b0;
        end
        default: repeat (n) step_cycle();   // plain wait
    endcase
endtask

//==========================================================================
// a dry pass over the stimulus file only adds up the test lengths
//==========================================================================
task automatic process_file(input bit dry);
    logic [8*24-1:0]  tok;
    logic [8*128-1:0] rest;
    int fd;
    int rc;
    int n;
    int exp_dir;
    int exp_p;
    int exp_a;
    int errs_before;
    errs_before = err_cnt;
    fd = $fopen("tb/usb_ctrl_stimulus.txt", "r");
    if (fd == 0)
    begin
        $display("could not open the stimulus file tb/usb_ctrl_stimulus.txt");
        err_cnt++;
        return;
    end
    while ($fscanf(fd, "%s", tok) == 1)
    begin
        if (tok == "#")
            rc = $fgets(rest, fd);          // comment line
        else if (tok == "q")
        begin
            rc = $fscanf(fd, "%h", n);
            if (dry)
                cycle_limit += 3;
            else
                rx_q.push_back(byte_t'(n));
        end
        else if (tok == "r" || tok == "k" || tok == "f" || tok == "b" || tok == "w")
        begin
            rc = $fscanf(fd, "%d", n);
            if (!dry)
                run_op(tok[7:0], n);
            else if (tok == "r")
                cycle_limit += 3 * n;
            else if (tok == "k" || tok == "w")
                cycle_limit += n;
        end
        else if (tok == "expect")
        begin
            rc = $fscanf(fd, "%d %d %d", exp_dir, exp_p, exp_a);
            if (dry)
                cycle_limit += SETTLE_MAX + DRAIN;
            else
            begin
                n = 0;
                while (n < SETTLE_MAX && !(rx_q.size() == 0 && busy_left == 0
                       && full_left == 0 && pulse_cnt >= exp_p && ack_cnt >= exp_a
                       && usb_dir == usb_dir_e'(exp_dir[0])))
                begin
                    step_cycle();
                    n++;
                end
                repeat (DRAIN) step_cycle();
                check_dir(usb_dir_e'(exp_dir[0]), usb_dir);
                check_count("motor pulses", exp_p, pulse_cnt);
                check_count("ack writes", exp_a, ack_cnt);
                check_byte(ACK_BYTE, tx_seen);
                if (err_cnt != errs_before)
                    test_ok = 1'b0;
                $display("%0s: %0s", tname, test_ok ? "ok" : "failed");
                pass_cnt += test_ok ? 1 : 0;
                fail_cnt += test_ok ? 0 : 1;
            end
        end
        else if (!dry)
        begin
            tname       = tok;              // new test starts here
            pulse_cnt   = 0;
            ack_cnt     = 0;
            tx_seen     = ACK_BYTE;
            test_ok     = 1'b1;
            errs_before = err_cnt;
        end
    end
    $fclose(fd);
endtask

initial
begin
    cycle_limit = 16 + 200;                 // reset plus margin
    process_file(1'b1);
    repeat (16) @(negedge I_sys_clk);
    I_sys_rst = 1'b0;
    process_file(1'b0);
    $display("tests passed %0d, failed %0d, other errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0 && pass_cnt > 0)
        $display("TEST RESULT: PASS");
    else
        $display("TEST RESULT: FAIL");
    $finish;
end

endmodule

`default_nettype wire

//--- tb/usb_ctrl_stimulus.txt
# columns: test name, ops q <hex byte>, r <filler bytes>, k <cycles key held>,
# f <cycles tx_full high>, b <cycles motor_busy high>, w <cycles>, expect <dir> <pulses> <acks>
after_reset        w 4 expect 0 0 0
dir_sequence       q ff q 00 q ff q 00 q ff w 30 expect 1 0 0
motor_and_filler   q 02 r 5 q 02 q 02 r 3 w 50 expect 1 3 0
busy_backpressure  b 80 q ff q 02 r 4 q 02 q 00 q 02 r 3 w 100 expect 0 3 0
key_presses        k 1 w 5 k 6 w 5 expect 0 0 2
key_while_full     f 30 w 2 k 2 w 4 k 2 w 32 expect 0 0 1
